//--- Bender.yml
package:
  name: loopback

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/loopback_pkg.sv
      - common/outbuf_if.sv
      - buffer/sync_fifo.sv
      - buffer/outbuf_stage.sv
      - verilog/copy_stage.sv
      - verilog/burst_writer.sv
      - verilog/perf_counters.sv
      - verilog/loopback_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/loopback_chk.sv
      - verif/loopback_tb.sv

//--- buffer/outbuf_stage.sv
`timescale 1ns/1ns

`include "loopback_params.svh"

module outbuf_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                push,
  input  loopback_pkg::data_t data_in,
  output logic                room,
  outbuf_if.source            ob
);
  import loopback_pkg::*;

  localparam int DEPTH = 1 << `LB_FIFO_AW;

  data_t  mem [DEPTH];
  level_t wptr;
  level_t rptr;
  level_t level;        // words held
  level_t credit;       // words not yet claimed by a burst
  level_t credit_next;
  logic   do_push;
  logic   do_pop;

  // ----------------------------------------------------------------------
  // fall-through storage
  // ----------------------------------------------------------------------
  assign level   = wptr - rptr;
  assign do_push = push && (level != level_t'(DEPTH));
  assign do_pop  = ob.pop && (level != '0);

  // two words may still be in flight in the copy stage, plus the one popped now
  assign room = (level <= level_t'(DEPTH - 3));

  assign ob.data = mem[rptr[`LB_FIFO_AW-1:0]];  // head visible while not empty

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wptr[`LB_FIFO_AW-1:0]] <= data_in;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wptr <= wptr + 1'b1;
      end
      if (do_pop)
      begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // burst credit
  // ----------------------------------------------------------------------
  // push and take may land in the same cycle
  assign credit_next = credit + level_t'(do_push)
                     - (ob.take ? level_t'(`LB_BURST_LEN) : level_t'(0));

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      credit         <= '0;
      ob.burst_ready <= 1'b0;
    end
    else
    begin
      credit         <= credit_next;
      ob.burst_ready <= (credit_next >= level_t'(`LB_BURST_LEN));  // tracks credit
    end
  end

endmodule

//--- buffer/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
  parameter int WIDTH = 64,
  parameter int AW    = 5
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             push,
  input  logic [WIDTH-1:0] data_in,
  input  logic             pop,
  output logic [WIDTH-1:0] data_out,
  output logic             empty,
  output logic             full
);

  localparam int DEPTH = 1 << AW;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW:0]      wptr;  // extra msb tells full from empty
  logic [AW:0]      rptr;
  logic             do_push;
  logic             do_pop;

  // ----------------------------------------------------------------------
  // status
  // ----------------------------------------------------------------------
  assign empty = (wptr == rptr);
  assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  assign do_push = push && !full;   // push on full is dropped
  assign do_pop  = pop && !empty;   // pop on empty is dropped

  // ----------------------------------------------------------------------
  // storage and registered read port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wptr[AW-1:0]] <= data_in;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_pop)
    begin
      data_out <= mem[rptr[AW-1:0]];  // valid the cycle after pop
    end
  end

  // ----------------------------------------------------------------------
  // pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wptr <= wptr + 1'b1;
      end
      if (do_pop)
      begin
        rptr <= rptr + 1'b1;
      end
    end
  end

endmodule

//--- common/loopback_params.svh
`ifndef LOOPBACK_PARAMS_SVH
`define LOOPBACK_PARAMS_SVH

// ----------------------------------------------------------------------
// data path sizing
// ----------------------------------------------------------------------
`define LB_DATA_W     64            // bits per data word
`define LB_FIFO_AW    5             // 32 entries in each buffer

// ----------------------------------------------------------------------
// write side
// ----------------------------------------------------------------------
`define LB_BURST_LEN  16            // words per burst
`define LB_WR_BASE    32'h0100_0000 // first burst lands here

`endif

//--- common/loopback_pkg.sv
package loopback_pkg;

  `include "loopback_params.svh"

  // ----------------------------------------------------------------------
  // shared data path types
  // ----------------------------------------------------------------------

  // one payload word, as pushed in and written out
  typedef logic [`LB_DATA_W-1:0] data_t;

  // byte address on the write port
  typedef logic [31:0] addr_t;

  // fill level or burst credit, needs one bit above the buffer address
  typedef logic [`LB_FIFO_AW:0] level_t;

  // event counter value, wraps
  typedef logic [31:0] count_t;

endpackage

//--- common/outbuf_if.sv
`timescale 1ns/1ns

interface outbuf_if;
  import loopback_pkg::*;

  data_t data;         // head of the output buffer
  logic  burst_ready;  // a whole burst is waiting
  logic  take;         // writer claims one burst
  logic  pop;          // writer removes the head word

  // output buffer side
  modport source (
    output data,
    output burst_ready,
    input  take,
    input  pop
  );

  // burst writer side
  modport sink (
    input  data,
    input  burst_ready,
    output take,
    output pop
  );

endinterface

//--- src.f
+incdir+common
common/loopback_pkg.sv
common/outbuf_if.sv
buffer/sync_fifo.sv
buffer/outbuf_stage.sv
verilog/copy_stage.sv
verilog/burst_writer.sv
verilog/perf_counters.sv
verilog/loopback_top.sv
verif/loopback_chk.sv
verif/loopback_tb.sv

//--- verif/loopback_chk.sv
`timescale 1ns/1ns

module loopback_chk (
  input logic                clk,
  input logic                resetn,
  input logic                in_push,
  input logic                in_full,
  input logic                burst_start,
  input logic                wr_valid,
  input loopback_pkg::data_t wr_data,
  input logic                wr_ready,
  input logic                wr_last
);

  // ----------------------------------------------------------------------
  // write port rules
  // ----------------------------------------------------------------------
  // a stalled word must not change
  wr_hold: assert property (@(posedge clk) disable iff (!resetn)
    (wr_valid && !wr_ready) |=> ($stable(wr_valid) && $stable(wr_data) && $stable(wr_last)))
    else $error("write port changed while stalled");

  start_valid: assert property (@(posedge clk) disable iff (!resetn)
    burst_start |=> wr_valid)  // stream opens the cycle after a start
    else $error("wr_valid did not follow burst_start");

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------
  no_push_full: assert property (@(posedge clk) disable iff (!resetn)
    !(in_push && in_full))
    else $error("push while the input buffer is full");

endmodule

bind loopback_top loopback_chk u_chk (
  .clk         ( clk         ),
  .resetn      ( resetn      ),
  .in_push     ( in_push     ),
  .in_full     ( in_full     ),
  .burst_start ( burst_start ),
  .wr_valid    ( wr_valid    ),
  .wr_data     ( wr_data     ),
  .wr_ready    ( wr_ready    ),
  .wr_last     ( wr_last     )
);

//--- verif/loopback_tb.sv
`timescale 1ns/1ns

`include "loopback_params.svh"

module loopback_tb;
  import loopback_pkg::*;

  localparam int N_WORDS   = 480;               // 30 whole bursts
  localparam int TIMEOUT   = N_WORDS * 8 + 1000; // cycles
  localparam int SLOW_SPAN = 256;               // cycles per wr_ready phase

  logic   clk;
  logic   resetn;
  logic   in_push;
  data_t  in_data;
  logic   in_full;
  logic   burst_start;
  addr_t  burst_addr;
  logic   wr_valid;
  data_t  wr_data;
  logic   wr_ready;
  logic   wr_last;
  count_t words_in;
  count_t words_out;
  count_t bursts_done;

  integer seed;
  int     wd_cycles;   // watchdog count
  int     tb_cycle;
  int     n_pushed;
  int     n_xfer;
  int     n_bursts;
  logic   saw_full;    // input buffer filled at least once
  data_t  model_q[$];  // words pushed but not yet written out

  loopback_top u_loopback_top (
    .clk         ( clk         ),
    .resetn      ( resetn      ),
    .in_push     ( in_push     ),
    .in_data     ( in_data     ),
    .in_full     ( in_full     ),
    .burst_start ( burst_start ),
    .burst_addr  ( burst_addr  ),
    .wr_valid    ( wr_valid    ),
    .wr_data     ( wr_data     ),
    .wr_ready    ( wr_ready    ),
    .wr_last     ( wr_last     ),
    .words_in    ( words_in    ),
    .words_out   ( words_out   ),
    .bursts_done ( bursts_done )
  );

  // ----------------------------------------------------------------------
  // error handling and compare tasks
  // ----------------------------------------------------------------------
  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic fail_plain(input string what);
    $display("ERROR: %s", what);
    stop_run();
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus and model, one call per cycle
  // ----------------------------------------------------------------------
  task automatic drive_inputs();
    logic slow;
    slow     = ((tb_cycle / SLOW_SPAN) % 2) == 1;
    in_push  = (n_pushed < N_WORDS) && !in_full && (($random(seed) & 1) == 1);
    in_data  = {$random(seed), $random(seed)};
    if (slow)
    begin
      wr_ready = (($random(seed) & 7) == 0);  // long back-pressure stretch
    end
    else
    begin
      wr_ready = (($random(seed) & 3) != 0);
    end
  endtask

  task automatic observe_cycle();
    data_t exp_word;
    addr_t exp_addr;
    if (in_full)
    begin
      saw_full = 1'b1;
    end
    if (in_push)
    begin
      model_q.push_back(in_data);
      n_pushed++;
    end
    if (burst_start)
    begin
      exp_addr = addr_t'(`LB_WR_BASE) + addr_t'(n_bursts * `LB_BURST_LEN * 8);
      check_addr("burst_addr", burst_addr, exp_addr);
      n_bursts++;
    end
    if (wr_valid)
    begin
      check_flag("wr_last", wr_last, (n_xfer % `LB_BURST_LEN) == `LB_BURST_LEN - 1);
    end
    if (wr_valid && wr_ready)
    begin
      if (n_xfer >= n_bursts * `LB_BURST_LEN)
      begin
        fail_plain("a word was written without a started burst");
      end
      if (model_q.size() == 0)
      begin
        fail_plain("a word was written that was never pushed");
      end
      exp_word = model_q.pop_front();
      check_word("wr_data", wr_data, exp_word);
      n_xfer++;
    end
  endtask

  // ----------------------------------------------------------------------
  // clock and watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    wd_cycles = 0;
    while (wd_cycles < TIMEOUT)
    begin
      @(posedge clk);
      wd_cycles++;
    end
    fail_plain($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT));
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    seed     = 32'h5764_726d;
    resetn   = 1'b0;
    in_push  = 1'b0;
    in_data  = '0;
    wr_ready = 1'b0;
    tb_cycle = 0;
    n_pushed = 0;
    n_xfer   = 0;
    n_bursts = 0;
    saw_full = 1'b0;

    repeat (2) @(posedge clk);  // two reset cycles
    @(negedge clk);
    resetn = 1'b1;
    #1;
    check_flag("burst_start", burst_start, 1'b0);
    check_flag("wr_valid", wr_valid, 1'b0);
    check_flag("wr_last", wr_last, 1'b0);
    check_flag("in_full", in_full, 1'b0);
    check_count("words_in", words_in, '0);
    check_count("words_out", words_out, '0);
    check_count("bursts_done", bursts_done, '0);

    while ((n_pushed < N_WORDS) || (n_xfer < N_WORDS))
    begin
      drive_inputs();
      #1;  // well clear of both edges
      observe_cycle();
      @(negedge clk);
      tb_cycle++;
    end

    in_push  = 1'b0;
    wr_ready = 1'b0;
    #1;
    check_count("words_in", words_in, count_t'(n_pushed));
    check_count("words_out", words_out, count_t'(n_xfer));
    check_count("bursts_done", bursts_done, count_t'(n_xfer / `LB_BURST_LEN));
    check_count("burst_start count", count_t'(n_bursts), count_t'(n_xfer / `LB_BURST_LEN));

    if (!saw_full)
    begin
      fail_plain("in_full never rose during the back-pressure phases");
    end
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- verilog/burst_writer.sv
`timescale 1ns/1ns

`include "loopback_params.svh"

module burst_writer (
  input  logic                clk,
  input  logic                resetn,
  outbuf_if.sink              ob,
  output logic                burst_start,
  output loopback_pkg::addr_t burst_addr,
  output logic                wr_valid,
  output loopback_pkg::data_t wr_data,
  input  logic                wr_ready,
  output logic                wr_last
);
  import loopback_pkg::*;

  localparam int BW = $clog2(`LB_BURST_LEN);

  logic          active;     // a burst is being streamed
  logic [BW-1:0] beat;       // words sent in this burst
  addr_t         burst_idx;  // bursts started so far
  logic          fire;

  // ----------------------------------------------------------------------
  // burst start
  // ----------------------------------------------------------------------
  assign burst_start = !active && ob.burst_ready;
  assign ob.take     = burst_start;  // claim credit with the start
  assign burst_addr  = addr_t'(`LB_WR_BASE)
                     + burst_idx * addr_t'(`LB_BURST_LEN * 8);  // 8 bytes per word

  // ----------------------------------------------------------------------
  // word stream
  // ----------------------------------------------------------------------
  assign wr_valid = active;
  assign wr_data  = ob.data;  // head only moves on a transfer
  assign wr_last  = active && (beat == BW'(`LB_BURST_LEN - 1));
  assign fire     = wr_valid && wr_ready;
  assign ob.pop   = fire;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      active    <= 1'b0;
      beat      <= '0;
      burst_idx <= '0;
    end
    else
    begin
      if (burst_start)
      begin
        active    <= 1'b1;
        burst_idx <= burst_idx + 1'b1;
      end
      if (fire)
      begin
        beat <= beat + 1'b1;  // wraps to zero after the last beat
        if (wr_last)
        begin
          active <= 1'b0;  // back to idle, next start a cycle later
        end
      end
    end
  end

endmodule

//--- verilog/copy_stage.sv
`timescale 1ns/1ns

module copy_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                fifo_empty,
  input  loopback_pkg::data_t fifo_data,
  input  logic                room,
  output logic                fifo_pop,
  output logic                out_push,
  output loopback_pkg::data_t out_data
);

  logic pop_q;  // fifo read port holds a fresh word

  // pull whenever there is a word and downstream has space
  assign fifo_pop = !fifo_empty && room;

  // ----------------------------------------------------------------------
  // valid pipe, two steps from pop to push
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      pop_q    <= 1'b0;
      out_push <= 1'b0;
    end
    else
    begin
      pop_q    <= fifo_pop;
      out_push <= pop_q;
    end
  end

  // data follows its valid by one register
  always_ff @(posedge clk)
  begin
    if (pop_q)
    begin
      out_data <= fifo_data;
    end
  end

endmodule

//--- verilog/loopback_top.sv
`timescale 1ns/1ns

`include "loopback_params.svh"

module loopback_top (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 in_push,
  input  loopback_pkg::data_t  in_data,
  output logic                 in_full,
  output logic                 burst_start,
  output loopback_pkg::addr_t  burst_addr,
  output logic                 wr_valid,
  output loopback_pkg::data_t  wr_data,
  input  logic                 wr_ready,
  output logic                 wr_last,
  output loopback_pkg::count_t words_in,
  output loopback_pkg::count_t words_out,
  output loopback_pkg::count_t bursts_done
);
  import loopback_pkg::*;

  logic  inbuf_pop;
  logic  inbuf_empty;
  data_t inbuf_data;
  logic  ob_push;
  data_t ob_data;
  logic  ob_room;
  logic  wr_fire;

  outbuf_if u_ob_if ();

  assign wr_fire = wr_valid && wr_ready;  // one word accepted

  // ----------------------------------------------------------------------
  // input buffer -> copy stage -> output buffer -> burst writer
  // ----------------------------------------------------------------------
  sync_fifo #(
    .WIDTH     ( `LB_DATA_W  ),
    .AW        ( `LB_FIFO_AW )
  ) u_inbuf (
    .clk       ( clk         ),
    .resetn    ( resetn      ),
    .push      ( in_push     ),
    .data_in   ( in_data     ),
    .pop       ( inbuf_pop   ),
    .data_out  ( inbuf_data  ),
    .empty     ( inbuf_empty ),
    .full      ( in_full     )
  );

  copy_stage u_copy (
    .clk        ( clk         ),
    .resetn     ( resetn      ),
    .fifo_empty ( inbuf_empty ),
    .fifo_data  ( inbuf_data  ),
    .room       ( ob_room     ),
    .fifo_pop   ( inbuf_pop   ),
    .out_push   ( ob_push     ),
    .out_data   ( ob_data     )
  );

  outbuf_stage u_outbuf (
    .clk     ( clk     ),
    .resetn  ( resetn  ),
    .push    ( ob_push ),
    .data_in ( ob_data ),
    .room    ( ob_room ),
    .ob      ( u_ob_if )
  );

  burst_writer u_writer (
    .clk         ( clk         ),
    .resetn      ( resetn      ),
    .ob          ( u_ob_if     ),
    .burst_start ( burst_start ),
    .burst_addr  ( burst_addr  ),
    .wr_valid    ( wr_valid    ),
    .wr_data     ( wr_data     ),
    .wr_ready    ( wr_ready    ),
    .wr_last     ( wr_last     )
  );

  perf_counters u_perf (
    .clk         ( clk         ),
    .resetn      ( resetn      ),
    .in_push     ( in_push     ),
    .wr_fire     ( wr_fire     ),
    .wr_last     ( wr_last     ),
    .words_in    ( words_in    ),
    .words_out   ( words_out   ),
    .bursts_done ( bursts_done )
  );

endmodule

//--- verilog/perf_counters.sv
`timescale 1ns/1ns

module perf_counters (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 in_push,
  input  logic                 wr_fire,
  input  logic                 wr_last,
  output loopback_pkg::count_t words_in,
  output loopback_pkg::count_t words_out,
  output loopback_pkg::count_t bursts_done
);
  import loopback_pkg::*;

  // ----------------------------------------------------------------------
  // event counters, all wrap at 32 bits
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      words_in    <= '0;
      words_out   <= '0;
      bursts_done <= '0;
    end
    else
    begin
      if (in_push)
      begin
        words_in <= words_in + count_t'(1);  // every push strobe
      end
      if (wr_fire)
      begin
        words_out <= words_out + count_t'(1);
      end
      if (wr_fire && wr_last)
      begin
        bursts_done <= bursts_done + count_t'(1);  // final beat accepted
      end
    end
  end

endmodule
